/* Bender.yml */
package:
  name: square_stream

sources:
  - design/dsp_pkg.sv
  - design/axis_skid_buffer.sv
  - design/axis_x2.sv
  - design/square_stream_top.sv
  - target: test
    files:
      - testbench/square_stream_checker.sv
      - testbench/square_stream_monitor.sv
      - testbench/square_stream_tb.sv

/* design/axis_skid_buffer.sv */
`timescale 1ns/1ns

// two-entry register slice on a valid/ready stream
// in_ready and out_valid both come straight from flops, which cuts the
// combinational ready path between neighbors
module axis_skid_buffer (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [dsp_pkg::stream_width-1:0] in_data,
  input  logic                             in_valid,
  output logic                             in_ready,
  output logic [dsp_pkg::stream_width-1:0] out_data,
  output logic                             out_valid,
  input  logic                             out_ready
);

  dsp_pkg::skid_state_t state;

  // main holds the word on offer, skid catches one extra under back-pressure
  logic [dsp_pkg::stream_width-1:0] main_data;
  logic [dsp_pkg::stream_width-1:0] skid_data;

  logic ready_q;
  logic valid_q;

  logic in_xfer;
  logic out_xfer;

  logic main_load_in;
  logic main_load_skid;
  logic skid_load;

  assign in_xfer = in_valid && ready_q;
  assign out_xfer = valid_q && out_ready;

  // a new word goes straight to main when main is empty or leaving now
  assign main_load_in = in_xfer && ((state == dsp_pkg::empty) || out_xfer);

  // main is stuck, so the arriving word parks in the skid register
  assign skid_load = in_xfer && (state == dsp_pkg::busy) && !out_xfer;

  // main drains, the older parked word moves up to keep arrival order
  assign main_load_skid = (state == dsp_pkg::full) && out_xfer;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= dsp_pkg::empty;
      ready_q <= 1'b1;
      valid_q <= 1'b0;
    end else begin
      unique case (state)
        dsp_pkg::empty: begin
          if (in_xfer) begin
            state <= dsp_pkg::busy;
            valid_q <= 1'b1;
          end
        end
        dsp_pkg::busy: begin
          if (in_xfer && !out_xfer) begin
            // second word held, stop taking more
            state <= dsp_pkg::full;
            ready_q <= 1'b0;
          end else if (!in_xfer && out_xfer) begin
            state <= dsp_pkg::empty;
            valid_q <= 1'b0;
          end
        end
        dsp_pkg::full: begin
          if (out_xfer) begin
            state <= dsp_pkg::busy;
            ready_q <= 1'b1;
          end
        end
        default: begin
          state <= dsp_pkg::empty;
          ready_q <= 1'b1;
          valid_q <= 1'b0;
        end
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (main_load_in) begin
      main_data <= in_data;
    end else if (main_load_skid) begin
      main_data <= skid_data;
    end
  end

  always_ff @(posedge clk) begin
    if (skid_load) begin
      skid_data <= in_data;
    end
  end

  assign in_ready = ready_q;
  assign out_valid = valid_q;
  assign out_data = main_data;

endmodule

/* design/axis_x2.sv */
`timescale 1ns/1ns

// two-lane squarer, Q2.14 in and Q4.12 out
// stage 1 registers the full product, stage 2 the shifted result
// each stage advances when the stage after it is empty or being taken
module axis_x2 (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [dsp_pkg::stream_width-1:0] in_data,
  input  logic                             in_valid,
  output logic                             in_ready,
  output logic [dsp_pkg::stream_width-1:0] out_data,
  output logic                             out_valid,
  input  logic                             out_ready
);

  localparam int w = dsp_pkg::sample_width;
  localparam int pw = dsp_pkg::product_width;

  // lane view of the incoming word
  logic signed [w-1:0] in_sample [dsp_pkg::parallel_samples];

  // stage 1, full products
  logic signed [pw-1:0] prod_q [dsp_pkg::parallel_samples];
  logic                 s1_valid;
  logic                 s1_en;

  // products after the rescale, still full width
  logic signed [pw-1:0] prod_shifted [dsp_pkg::parallel_samples];

  // stage 2, packed results ready to leave
  logic [dsp_pkg::stream_width-1:0] res_q;
  logic                             s2_valid;
  logic                             s2_en;

  // stage 2 may load if it holds nothing or its word leaves this cycle
  assign s2_en = !s2_valid || out_ready;

  // stage 1 may load if it is empty or its word moves into stage 2
  assign s1_en = !s1_valid || s2_en;

  assign in_ready = s1_en;

  always_comb begin
    for (int lane = 0; lane < dsp_pkg::parallel_samples; lane++) begin
      in_sample[lane] = in_data[lane*w +: w];
    end
  end

  always_comb begin
    for (int lane = 0; lane < dsp_pkg::parallel_samples; lane++) begin
      // arithmetic shift, so the sign of the product is kept
      prod_shifted[lane] = prod_q[lane] >>> dsp_pkg::square_shift;
    end
  end

  // stage valid bits
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (s1_en) begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_valid <= 1'b0;
    end else if (s2_en) begin
      s2_valid <= s1_valid;
    end
  end

  // stage 1 payload
  // (-32768)^2 = 2^30 is the largest product and fits the signed 32 bits
  always_ff @(posedge clk) begin
    if (s1_en && in_valid) begin
      for (int lane = 0; lane < dsp_pkg::parallel_samples; lane++) begin
        prod_q[lane] <= in_sample[lane] * in_sample[lane];
      end
    end
  end

  // stage 2 payload
  // shifted value is at most 16384, the low bits hold it without saturation
  always_ff @(posedge clk) begin
    if (s2_en && s1_valid) begin
      for (int lane = 0; lane < dsp_pkg::parallel_samples; lane++) begin
        res_q[lane*w +: w] <= prod_shifted[lane][w-1:0];
      end
    end
  end

  assign out_data = res_q;
  assign out_valid = s2_valid;

endmodule

/* design/dsp_pkg.sv */
package dsp_pkg;

  // one input sample, signed Q2.14
  localparam int sample_width = 16;
  localparam int sample_frac_bits = 14;
  localparam int sample_int_bits = sample_width - sample_frac_bits;

  // samples packed side by side in one stream word, lane 0 in the low bits
  localparam int parallel_samples = 2;
  localparam int stream_width = sample_width * parallel_samples;

  // full square of a sample, Q4.28
  localparam int product_width = 2 * sample_width;
  localparam int product_frac_bits = 2 * sample_frac_bits;

  // output keeps the sample width, so 2*int_bits integer bits remain
  localparam int result_frac_bits = sample_width - 2 * sample_int_bits;

  // arithmetic right shift from Q4.28 down to Q4.12
  localparam int square_shift = product_frac_bits - result_frac_bits;

  // occupancy of the two-entry register slice
  // empty: nothing held, busy: output register only, full: output and skid
  typedef enum logic [1:0] {
    empty = 2'd0,
    busy  = 2'd1,
    full  = 2'd2
  } skid_state_t;

endpackage

/* design/square_stream_top.sv */
`timescale 1ns/1ns

// streaming squarer subsystem
// input slice -> two-stage squarer -> output slice, four registers deep
// in_ready comes from a flop in the input slice, out_valid from the output slice
module square_stream_top (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [dsp_pkg::stream_width-1:0] in_data,
  input  logic                             in_valid,
  output logic                             in_ready,
  output logic [dsp_pkg::stream_width-1:0] out_data,
  output logic                             out_valid,
  input  logic                             out_ready
);

  // input slice to squarer
  logic [dsp_pkg::stream_width-1:0] sq_in_data;
  logic                             sq_in_valid;
  logic                             sq_in_ready;

  // squarer to output slice
  logic [dsp_pkg::stream_width-1:0] sq_out_data;
  logic                             sq_out_valid;
  logic                             sq_out_ready;

  axis_skid_buffer u_in_slice (
    .clk       (clk),
    .reset     (reset),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (sq_in_data),
    .out_valid (sq_in_valid),
    .out_ready (sq_in_ready)
  );

  // the squarer's ready is combinational, registered slices on both sides
  axis_x2 u_square (
    .clk       (clk),
    .reset     (reset),
    .in_data   (sq_in_data),
    .in_valid  (sq_in_valid),
    .in_ready  (sq_in_ready),
    .out_data  (sq_out_data),
    .out_valid (sq_out_valid),
    .out_ready (sq_out_ready)
  );

  axis_skid_buffer u_out_slice (
    .clk       (clk),
    .reset     (reset),
    .in_data   (sq_out_data),
    .in_valid  (sq_out_valid),
    .in_ready  (sq_out_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

/* testbench/square_stream_checker.sv */
`timescale 1ns/1ns

// handshake and reset properties on the squarer top level
module square_stream_checker (
  input logic                             clk,
  input logic                             reset,
  input logic [dsp_pkg::stream_width-1:0] out_data,
  input logic                             out_valid,
  input logic                             out_ready,
  input logic                             in_ready,
  input dsp_pkg::skid_state_t             in_slice_state
);

  int failures = 0;

  // a stalled output word must not move or vanish
  property out_held_p;
    @(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_data);
  endproperty

  out_held_a: assert property (out_held_p)
    else begin
      failures++;
      $error("out_valid or out_data changed while out_ready was low");
    end

  out_idle_after_reset_a: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      failures++;
      $error("out_valid high on the cycle after reset");
    end

  in_ready_after_reset_a: assert property (@(posedge clk) reset |=> in_ready)
    else begin
      failures++;
      $error("in_ready low on the cycle after reset");
    end

  // a full input slice has to refuse new words
  full_not_ready_a: assert property (
    @(posedge clk) disable iff (reset)
      !((in_slice_state == dsp_pkg::full) && in_ready))
    else begin
      failures++;
      $error("input slice full while in_ready is high");
    end

endmodule

/* testbench/square_stream_monitor.sv */
`timescale 1ns/1ns

// predicts the squared words, compares them at the output port and counts errors
module square_stream_monitor (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [dsp_pkg::stream_width-1:0] in_data,
  input  logic                             in_valid,
  input  logic                             in_ready,
  input  logic [dsp_pkg::stream_width-1:0] out_data,
  input  logic                             out_valid,
  input  logic                             out_ready,
  input  logic [dsp_pkg::stream_width-1:0] table_expect,
  input  logic                             table_expect_valid,
  input  logic                             end_of_test,
  output int                               data_errors,
  output int                               other_errors,
  output int                               in_count,
  output int                               out_count
);

  localparam int w = dsp_pkg::sample_width;
  localparam int sw = dsp_pkg::stream_width;
  // input slice, squarer and output slice hold two words each
  localparam int max_held = 6;

  logic [sw-1:0] expect_q [$];
  logic [sw-1:0] expected;
  logic          reset_prev = 1'b0;
  logic          end_seen = 1'b0;
  int            data_err_cnt = 0;
  int            other_err_cnt = 0;
  int            in_cnt = 0;
  int            out_cnt = 0;
  int            held;

  // square of the raw sample integer, arithmetic shift down to Q4.12
  function automatic logic [sw-1:0] square_word(input logic [sw-1:0] word);
    logic [sw-1:0] res;
    longint        sample;
    longint        square;
    longint        shifted;
    res = '0;
    for (int lane = 0; lane < dsp_pkg::parallel_samples; lane++) begin
      sample = longint'($signed(word[lane*w +: w]));
      square = sample * sample;
      shifted = square >>> dsp_pkg::square_shift;
      res[lane*w +: w] = shifted[w-1:0];
    end
    return res;
  endfunction

  always @(posedge clk) begin
    reset_prev <= reset;
    // first edge of reset is skipped, flops are still unknown there
    if (reset_prev) begin
      if (out_valid !== 1'b0) begin
        other_err_cnt++;
        $display("out_valid is not low during or right after reset");
      end
      if (in_ready !== 1'b1) begin
        other_err_cnt++;
        $display("in_ready is not high during or right after reset");
      end
    end
    if (!reset) begin
      held = in_cnt - out_cnt;
      if (held >= max_held && in_ready === 1'b1) begin
        other_err_cnt++;
        $display("in_ready still high with %0d words held inside", held);
      end
      if (in_valid && in_ready) begin
        if (table_expect_valid) begin
          expect_q.push_back(table_expect);
        end else begin
          expect_q.push_back(square_word(in_data));
        end
        in_cnt++;
      end
      if (out_valid && out_ready) begin
        if (expect_q.size() == 0) begin
          other_err_cnt++;
          $display("output word %h arrived with no matching input", out_data);
        end else begin
          expected = expect_q.pop_front();
          if (out_data !== expected) begin
            data_err_cnt++;
            $display("[FAIL] out_data expected %h actual %h", expected, out_data);
          end
        end
        out_cnt++;
      end
    end
    if (end_of_test && !end_seen) begin
      end_seen <= 1'b1;
      if (in_cnt != out_cnt) begin
        other_err_cnt++;
        $display("%0d words went in but %0d came out", in_cnt, out_cnt);
      end
      if (expect_q.size() != 0) begin
        other_err_cnt++;
        $display("%0d expected words never came out", expect_q.size());
      end
    end
  end

  assign data_errors = data_err_cnt;
  assign other_errors = other_err_cnt;
  assign in_count = in_cnt;
  assign out_count = out_cnt;

endmodule

/* testbench/square_stream_tb.sv */
`timescale 1ns/1ns

module square_stream_tb;

  localparam int sw = dsp_pkg::stream_width;
  localparam int w = dsp_pkg::sample_width;
  localparam int clk_period = 40;
  localparam int reset_cycles = 4;
  localparam int row_count = 21;
  localparam int random_words = 400;
  // gap of up to 3 plus one ready in eight at worst
  localparam int random_cycles_per_word = 12;
  localparam int drain_margin = 64;

  // samples, expected results, idle cycles before the offer, out_ready bit per cycle
  typedef struct packed {
    logic [w-1:0] s0;
    logic [w-1:0] s1;
    logic [w-1:0] e0;
    logic [w-1:0] e1;
    logic [7:0]   gap;
    logic [7:0]   ready_pat;
  } row_t;

  row_t stim [row_count] = '{
    // format corners, same value in both lanes
    '{16'h8000, 16'h8000, 16'h4000, 16'h4000, 8'd0, 8'hff},
    '{16'h7fff, 16'h7fff, 16'h3fff, 16'h3fff, 8'd1, 8'hff},
    '{16'h4000, 16'h4000, 16'h1000, 16'h1000, 8'd0, 8'hff},
    '{16'hffff, 16'hffff, 16'h0000, 16'h0000, 8'd2, 8'hff},
    '{16'h0001, 16'h0001, 16'h0000, 16'h0000, 8'd0, 8'hff},
    '{16'h00ff, 16'h00ff, 16'h0000, 16'h0000, 8'd0, 8'hff},
    '{16'h0100, 16'h0100, 16'h0001, 16'h0001, 8'd3, 8'hff},
    // different values per lane
    '{16'h4000, 16'h8000, 16'h1000, 16'h4000, 8'd0, 8'haa},
    '{16'h0100, 16'h2000, 16'h0001, 16'h0400, 8'd0, 8'h55},
    '{16'hcfc7, 16'h03e8, 16'h0915, 16'h000f, 8'd1, 8'hff},
    '{16'h7fff, 16'h0000, 16'h3fff, 16'h0000, 8'd0, 8'h33},
    '{16'hc000, 16'hff00, 16'h1000, 16'h0001, 8'd0, 8'hff},
    '{16'h5a82, 16'hffff, 16'h1fff, 16'h0000, 8'd0, 8'hff},
    // drain first, then six words held with out_ready low
    '{16'h0001, 16'h7fff, 16'h0000, 16'h3fff, 8'd8, 8'hff},
    '{16'h0100, 16'h0200, 16'h0001, 16'h0004, 8'd0, 8'h00},
    '{16'h0300, 16'h0400, 16'h0009, 16'h0010, 8'd0, 8'h00},
    '{16'h8000, 16'h7fff, 16'h4000, 16'h3fff, 8'd0, 8'h00},
    '{16'hff00, 16'hc000, 16'h0001, 16'h1000, 8'd0, 8'h00},
    '{16'h2000, 16'h4000, 16'h0400, 16'h1000, 8'd0, 8'h00},
    // stalled until out_ready comes back
    '{16'h03e8, 16'hcfc7, 16'h000f, 16'h0915, 8'd0, 8'hf0},
    '{16'h5a82, 16'h0100, 16'h1fff, 16'h0001, 8'd0, 8'hff}
  };

  logic          clk;
  logic          reset;
  logic [sw-1:0] in_data;
  logic          in_valid;
  logic          in_ready;
  logic [sw-1:0] out_data;
  logic          out_valid;
  logic          out_ready;

  logic [sw-1:0] table_expect;
  logic          table_expect_valid;
  logic          end_of_test;

  int data_errors;
  int other_errors;
  int in_count;
  int out_count;
  int assert_errors;
  int drain_wait;

  logic [31:0]   rand_state;
  logic [sw-1:0] rand_word;
  int            rand_gap;
  logic [7:0]    rand_pat;

  always #(clk_period / 2) clk = ~clk;

  square_stream_top square_stream_top_i (
    .clk       (clk),
    .reset     (reset),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  square_stream_monitor monitor_i (
    .clk                (clk),
    .reset              (reset),
    .in_data            (in_data),
    .in_valid           (in_valid),
    .in_ready           (in_ready),
    .out_data           (out_data),
    .out_valid          (out_valid),
    .out_ready          (out_ready),
    .table_expect       (table_expect),
    .table_expect_valid (table_expect_valid),
    .end_of_test        (end_of_test),
    .data_errors        (data_errors),
    .other_errors       (other_errors),
    .in_count           (in_count),
    .out_count          (out_count)
  );

  bind square_stream_top square_stream_checker checker_i (
    .clk            (clk),
    .reset          (reset),
    .out_data       (out_data),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .in_ready       (in_ready),
    .in_slice_state (u_in_slice.state)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // worst case per row is its gap plus two rounds of the ready pattern
  function automatic int table_cycles();
    int total;
    total = 0;
    for (int i = 0; i < row_count; i++) begin
      total += int'(stim[i].gap) + 16;
    end
    return total;
  endfunction

  // idle for gap cycles, then hold the word until in_ready takes it
  task automatic send_word(input logic [sw-1:0] data, input logic [sw-1:0] expect_word,
                           input logic expect_valid, input int gap,
                           input logic [7:0] ready_pat);
    int   cyc;
    logic taken;
    cyc = 0;
    if (gap > 0) begin
      in_valid = 1'b0;
    end
    repeat (gap) begin
      out_ready = ready_pat[cyc % 8];
      @(posedge clk);
      #2;
      cyc++;
    end
    in_data = data;
    table_expect = expect_word;
    table_expect_valid = expect_valid;
    in_valid = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      out_ready = ready_pat[cyc % 8];
      // in_ready only changes on a clock edge, so this is the value the next edge sees
      taken = in_ready;
      @(posedge clk);
      #2;
      cyc++;
    end
  endtask

  initial begin : watchdog
    longint limit_ns;
    limit_ns = 2 * longint'(table_cycles() + random_words * random_cycles_per_word
                            + drain_margin + reset_cycles) * clk_period;
    #(limit_ns);
    $display("watchdog timeout after %0d ns, the DUT stopped moving words", limit_ns);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    in_data = '0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    table_expect = '0;
    table_expect_valid = 1'b0;
    end_of_test = 1'b0;
    rand_state = 32'h506c;
    repeat (reset_cycles) @(posedge clk);
    #2;
    reset = 1'b0;

    for (int i = 0; i < row_count; i++) begin
      send_word({stim[i].s1, stim[i].s0}, {stim[i].e1, stim[i].e0}, 1'b1,
                int'(stim[i].gap), stim[i].ready_pat);
    end

    // random phase, expected words come from the monitor's own rule
    for (int n = 0; n < random_words; n++) begin
      rand_state = lcg_step(rand_state);
      rand_word[w-1:0] = rand_state[31:16];
      rand_state = lcg_step(rand_state);
      rand_word[sw-1:w] = rand_state[31:16];
      rand_state = lcg_step(rand_state);
      rand_gap = int'(rand_state[31:30]);
      // bit 0 set so the output never stalls for a whole pattern
      rand_pat = rand_state[23:16] | 8'h01;
      send_word(rand_word, '0, 1'b0, rand_gap, rand_pat);
    end

    in_valid = 1'b0;
    table_expect_valid = 1'b0;
    out_ready = 1'b1;
    drain_wait = 0;
    while (out_count != in_count && drain_wait < drain_margin) begin
      @(posedge clk);
      #2;
      drain_wait++;
    end
    end_of_test = 1'b1;
    repeat (2) @(posedge clk);
    #2;

    assert_errors = square_stream_top_i.checker_i.failures;
    $display("errors: data %0d, other %0d, assertion %0d; words in %0d, out %0d",
             data_errors, other_errors, assert_errors, in_count, out_count);
    if (data_errors == 0 && other_errors == 0 && assert_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
design/dsp_pkg.sv
design/axis_skid_buffer.sv
design/axis_x2.sv
design/square_stream_top.sv
testbench/square_stream_checker.sv
testbench/square_stream_monitor.sv
testbench/square_stream_tb.sv
